// ==== rtl/commu_pkg.sv ====
// commu package: packet framing, CRC, payload table and bit timing constants
package commu_pkg;

	// ------------------------------------------------------------------------
	// packet layout
	// ------------------------------------------------------------------------
	localparam logic [15:0] LEN_HEAD = 16'd12;
	localparam logic [15:0] LEN_TAIL = 16'd0;
	localparam logic [15:0] LEN_CRC  = 16'd2;

	// frame sync pattern, first two header bytes
	localparam logic [7:0] SYNC_0 = 8'hEB;
	localparam logic [7:0] SYNC_1 = 8'h90;

	// ------------------------------------------------------------------------
	// CRC-16 CCITT
	// ------------------------------------------------------------------------
	localparam logic [15:0] CRC_POLY = 16'h1021;
	localparam logic [15:0] CRC_INIT = 16'hFFFF;

	// ------------------------------------------------------------------------
	// bit timing
	// ------------------------------------------------------------------------
	// clock cycles per unit of tbit_period
	localparam logic [7:0] UNIT_CYCLES = 8'd1;

	// ------------------------------------------------------------------------
	// payload bytes per sample setting
	// ------------------------------------------------------------------------
	// short table, sample setting 20/10/5/2/1
	localparam logic [15:0] LOAD_20 = 16'd180;
	localparam logic [15:0] LOAD_10 = 16'd90;
	localparam logic [15:0] LOAD_5  = 16'd45;
	localparam logic [15:0] LOAD_2  = 16'd18;
	localparam logic [15:0] LOAD_1  = 16'd9;

	// device count classes
	localparam logic [1:0] MODE_LOW  = 2'd0;
	localparam logic [1:0] MODE_MID  = 2'd1;
	localparam logic [1:0] MODE_HIGH = 2'd3;

endpackage

// ==== rtl/commu_base.sv ====
// commu configuration decoder: device count and sample setting to length and bit timing
module commu_base (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic [7:0]  cfg_num_dev,
	input  logic [7:0]  cfg_sample,
	output logic [15:0] len_pkg,
	output logic [1:0]  mode_num_dev,
	output logic [15:0] tbit_frq,
	output logic [19:0] tbit_period
);
	import commu_pkg::*;

	logic [15:0] len_load;

	// ------------------------------------------------------------------------
	// stage 1: payload load and device count class
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			len_load     <= LOAD_20;
			mode_num_dev <= MODE_LOW;
		end else begin
			case (cfg_sample)
				8'd20:   len_load <= LOAD_20;
				8'd10:   len_load <= LOAD_10;
				8'd5:    len_load <= LOAD_5;
				8'd2:    len_load <= LOAD_2;
				8'd1:    len_load <= LOAD_1;
				default: len_load <= LOAD_20;
			endcase
			if (cfg_num_dev >= 8'd16)
				mode_num_dev <= MODE_HIGH;
			else if (cfg_num_dev >= 8'd8)
				mode_num_dev <= MODE_MID;
			else
				mode_num_dev <= MODE_LOW;
		end
	end

	// ------------------------------------------------------------------------
	// stage 2: total length and bit frequency
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			len_pkg  <= LEN_HEAD + LOAD_20 + LEN_TAIL + LEN_CRC;
			tbit_frq <= 16'd2000;
		end else begin
			len_pkg <= LEN_HEAD + len_load + LEN_TAIL + LEN_CRC;
			// more devices need a faster line for the same sample rate
			case (mode_num_dev)
				MODE_HIGH: begin
					case (cfg_sample)
						8'd10:   tbit_frq <= 16'd4000;
						8'd5:    tbit_frq <= 16'd2000;
						8'd2:    tbit_frq <= 16'd1000;
						8'd1:    tbit_frq <= 16'd500;
						default: tbit_frq <= 16'd5000;
					endcase
				end
				MODE_MID: begin
					case (cfg_sample)
						8'd10:   tbit_frq <= 16'd2000;
						8'd5:    tbit_frq <= 16'd1000;
						8'd2:    tbit_frq <= 16'd500;
						8'd1:    tbit_frq <= 16'd200;
						default: tbit_frq <= 16'd4000;
					endcase
				end
				default: begin
					case (cfg_sample)
						8'd10:   tbit_frq <= 16'd1000;
						8'd5:    tbit_frq <= 16'd500;
						8'd2:    tbit_frq <= 16'd200;
						8'd1:    tbit_frq <= 16'd200;
						default: tbit_frq <= 16'd2000;
					endcase
				end
			endcase
		end
	end

	// period in units, straight from the frequency
	always_comb begin
		case (tbit_frq)
			16'd5000: tbit_period = 20'd20;
			16'd4000: tbit_period = 20'd25;
			16'd2000: tbit_period = 20'd50;
			16'd1000: tbit_period = 20'd100;
			16'd500:  tbit_period = 20'd200;
			16'd200:  tbit_period = 20'd500;
			16'd100:  tbit_period = 20'd1000;
			default:  tbit_period = 20'd20;
		endcase
	end

	// every decoded frequency has its own nonzero period, period times frequency is fixed
	a_period_nonzero: assert property (@(posedge clk_sys) disable iff (!arst_n)
		tbit_period != 20'd0 && tbit_period * tbit_frq == 32'd100000);

endmodule

// ==== rtl/commu_tbit.sv ====
// commu bit tick generator: one pulse per bit period while the link runs
module commu_tbit (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        tbit_run,
	input  logic [19:0] tbit_period,
	output logic        tbit_tick
);
	import commu_pkg::*;

	logic [27:0] cnt;
	logic [27:0] cnt_load;

	// cycles per bit minus one
	assign cnt_load = tbit_period * UNIT_CYCLES - 28'd1;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cnt       <= '0;
			tbit_tick <= 1'b0;
		end else begin
			tbit_tick <= 1'b0;
			if (!tbit_run) begin
				// preset while stopped, the rising run edge starts a fresh count
				cnt <= cnt_load;
			end else if (cnt == 28'd0) begin
				cnt       <= cnt_load;
				tbit_tick <= 1'b1;
			end else begin
				cnt <= cnt - 28'd1;
			end
		end
	end

	// the framer keeps run high until the last stop bit has fully ended
	a_tick_run: assert property (@(posedge clk_sys) disable iff (!arst_n)
		tbit_tick |-> tbit_run);

endmodule

// ==== rtl/commu_crc16.sv ====
// commu CRC-16 CCITT accumulator, one byte per update strobe
module commu_crc16 (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        crc_clr,
	input  logic        crc_upd,
	input  logic [7:0]  tx_byte,
	output logic [15:0] crc_val
);
	import commu_pkg::*;

	// fold one byte in, msb first
	function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic [7:0] data);
		logic [15:0] r;
		int i;
		r = crc ^ {data, 8'h00};
		for (i = 0; i < 8; i++) begin
			if (r[15])
				r = {r[14:0], 1'b0} ^ CRC_POLY;
			else
				r = {r[14:0], 1'b0};
		end
		return r;
	endfunction

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			crc_val <= CRC_INIT;
		end else if (crc_clr) begin
			crc_val <= CRC_INIT;
		end else if (crc_upd) begin
			crc_val <= crc_step(crc_val, tx_byte);
		end
	end

endmodule

// ==== rtl/commu_frame.sv ====
// commu packet framer: header, payload and CRC bytes toward the serializer
module commu_frame (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        pkg_start,
	input  logic [7:0]  cfg_num_dev,
	input  logic [7:0]  cfg_sample,
	input  logic [15:0] len_pkg,
	input  logic [7:0]  data_in,
	output logic        data_rd,
	input  logic        tx_free,
	output logic [7:0]  tx_byte,
	output logic        tx_load,
	output logic        crc_clr,
	output logic        crc_upd,
	input  logic [15:0] crc_val,
	output logic        tbit_run,
	output logic        tx_busy,
	output logic        pkg_done
);
	import commu_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_HEAD,
		S_LOAD,
		S_CRC,
		S_DRAIN
	} state_t;

	state_t      state;
	logic [15:0] byte_cnt;
	logic [15:0] seq_num;
	logic        load_ok;
	logic [7:0]  next_byte;

	// a byte may go out once the serializer is free and the previous load is seen
	assign load_ok = (state == S_HEAD || state == S_LOAD || state == S_CRC) &&
		tx_free && !tx_load;
	assign data_rd  = (state == S_LOAD) && load_ok;
	assign tbit_run = (state != S_IDLE);
	assign tx_busy  = (state != S_IDLE);

	// ------------------------------------------------------------------------
	// byte select
	// ------------------------------------------------------------------------
	always_comb begin
		next_byte = 8'h00;
		case (state)
			S_HEAD: begin
				case (byte_cnt)
					16'd0:   next_byte = SYNC_0;
					16'd1:   next_byte = SYNC_1;
					16'd2:   next_byte = cfg_num_dev;
					16'd3:   next_byte = cfg_sample;
					16'd4:   next_byte = len_pkg[15:8];
					16'd5:   next_byte = len_pkg[7:0];
					16'd6:   next_byte = seq_num[15:8];
					16'd7:   next_byte = seq_num[7:0];
					// reserved header bytes
					default: next_byte = 8'h00;
				endcase
			end
			S_LOAD:  next_byte = data_in;
			// crc high byte first
			S_CRC:   next_byte = (byte_cnt == len_pkg - LEN_CRC) ? crc_val[15:8] : crc_val[7:0];
			default: next_byte = 8'h00;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (load_ok)
			tx_byte <= next_byte;
	end

	// ------------------------------------------------------------------------
	// sequencing
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state    <= S_IDLE;
			byte_cnt <= '0;
			seq_num  <= '0;
			tx_load  <= 1'b0;
			crc_clr  <= 1'b0;
			crc_upd  <= 1'b0;
			pkg_done <= 1'b0;
		end else begin
			tx_load  <= load_ok;
			crc_upd  <= load_ok && (state == S_HEAD || state == S_LOAD);
			crc_clr  <= 1'b0;
			pkg_done <= 1'b0;
			if (load_ok)
				byte_cnt <= byte_cnt + 16'd1;
			case (state)
				S_IDLE: begin
					// starts are only taken here, so a busy start is dropped
					if (pkg_start) begin
						state    <= S_HEAD;
						byte_cnt <= '0;
						crc_clr  <= 1'b1;
					end
				end
				S_HEAD: begin
					if (load_ok && byte_cnt == LEN_HEAD - 16'd1)
						state <= S_LOAD;
				end
				S_LOAD: begin
					if (load_ok && byte_cnt == len_pkg - LEN_CRC - 16'd1)
						state <= S_CRC;
				end
				S_CRC: begin
					if (load_ok && byte_cnt == len_pkg - 16'd1)
						state <= S_DRAIN;
				end
				S_DRAIN: begin
					// wait out the last stop bit
					if (tx_free && !tx_load) begin
						pkg_done <= 1'b1;
						seq_num  <= seq_num + 16'd1;
						state    <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// serializer drops tx_free only after it has seen the load
	a_load_free: assert property (@(posedge clk_sys) disable iff (!arst_n)
		tx_load |-> tx_free);

	// reads fall between the last header byte and the first crc byte
	a_rd_payload: assert property (@(posedge clk_sys) disable iff (!arst_n)
		data_rd |-> byte_cnt >= LEN_HEAD && byte_cnt < len_pkg - LEN_TAIL - LEN_CRC);

endmodule

// ==== rtl/commu_tx.sv ====
// commu byte serializer: start bit, eight data bits lsb first, stop bit
module commu_tx (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       tbit_tick,
	input  logic       tx_load,
	input  logic [7:0] tx_byte,
	output logic       tx_line,
	output logic       tx_free
);

	// stop, data, start from msb down to lsb
	logic [9:0] shreg;
	// ten bits plus the tick that closes the stop bit
	logic [3:0] bit_cnt;

	always_ff @(posedge clk_sys) begin
		if (tx_load)
			shreg <= {1'b1, tx_byte, 1'b0};
		else if (tbit_tick && bit_cnt > 4'd1)
			shreg <= {1'b1, shreg[9:1]};
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt <= 4'd0;
			tx_line <= 1'b1;
			tx_free <= 1'b1;
		end else if (tx_load) begin
			bit_cnt <= 4'd11;
			tx_free <= 1'b0;
		end else if (tbit_tick && bit_cnt != 4'd0) begin
			bit_cnt <= bit_cnt - 4'd1;
			if (bit_cnt > 4'd1)
				tx_line <= shreg[0];
			else
				// stop bit has lasted a full period
				tx_free <= 1'b1;
		end
	end

endmodule

// ==== rtl/commu_top.sv ====
// commu transmit top: decoder, tick generator, framer, CRC and serializer
module commu_top (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic [7:0]  cfg_num_dev,
	input  logic [7:0]  cfg_sample,
	input  logic        pkg_start,
	input  logic [7:0]  data_in,
	output logic        data_rd,
	output logic        tx_line,
	output logic        tx_busy,
	output logic        pkg_done,
	output logic [15:0] len_pkg,
	output logic [1:0]  mode_num_dev,
	output logic [15:0] tbit_frq,
	output logic [19:0] tbit_period
);

	logic        tbit_run;
	logic        tbit_tick;
	logic [7:0]  tx_byte;
	logic        tx_load;
	logic        tx_free;
	logic        crc_clr;
	logic        crc_upd;
	logic [15:0] crc_val;

	commu_base u_base (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.cfg_num_dev  (cfg_num_dev),
		.cfg_sample   (cfg_sample),
		.len_pkg      (len_pkg),
		.mode_num_dev (mode_num_dev),
		.tbit_frq     (tbit_frq),
		.tbit_period  (tbit_period)
	);

	commu_tbit u_tbit (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.tbit_run    (tbit_run),
		.tbit_period (tbit_period),
		.tbit_tick   (tbit_tick)
	);

	commu_crc16 u_crc16 (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.crc_clr (crc_clr),
		.crc_upd (crc_upd),
		.tx_byte (tx_byte),
		.crc_val (crc_val)
	);

	commu_frame u_frame (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.pkg_start   (pkg_start),
		.cfg_num_dev (cfg_num_dev),
		.cfg_sample  (cfg_sample),
		.len_pkg     (len_pkg),
		.data_in     (data_in),
		.data_rd     (data_rd),
		.tx_free     (tx_free),
		.tx_byte     (tx_byte),
		.tx_load     (tx_load),
		.crc_clr     (crc_clr),
		.crc_upd     (crc_upd),
		.crc_val     (crc_val),
		.tbit_run    (tbit_run),
		.tx_busy     (tx_busy),
		.pkg_done    (pkg_done)
	);

	commu_tx u_tx (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.tbit_tick (tbit_tick),
		.tx_load   (tx_load),
		.tx_byte   (tx_byte),
		.tx_line   (tx_line),
		.tx_free   (tx_free)
	);

endmodule

// ==== test/commu_rx_model.sv ====
// commu line decoder model: mid-bit sampling of the serial line, one report per byte
module commu_rx_model (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        rx_line,
	input  logic [27:0] bit_cycles,
	output logic        rx_valid,
	output logic [7:0]  rx_byte,
	output logic        rx_stop,
	output logic [27:0] rx_start_w
);

	logic        line_q;
	logic        active;
	logic        low_open;
	logic [27:0] cyc;
	logic [27:0] low_run;
	logic [3:0]  bit_idx;
	logic [7:0]  shreg;

	// the first low run spans the start bit plus any leading zero data bits
	function automatic logic [27:0] start_width(input logic [27:0] run, input logic [7:0] data);
		int k;
		k = 1;
		while (k < 9 && data[k-1] == 1'b0)
			k++;
		if (run % k == 0)
			return run / k;
		return run;
	endfunction

	always @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			line_q     <= 1'b1;
			active     <= 1'b0;
			low_open   <= 1'b0;
			cyc        <= '0;
			low_run    <= '0;
			bit_idx    <= '0;
			shreg      <= '0;
			rx_valid   <= 1'b0;
			rx_byte    <= '0;
			rx_stop    <= 1'b0;
			rx_start_w <= '0;
		end else begin
			line_q   <= rx_line;
			rx_valid <= 1'b0;
			if (!active) begin
				// falling edge opens a frame
				if (line_q && !rx_line) begin
					active   <= 1'b1;
					low_open <= 1'b1;
					cyc      <= 28'd1;
					low_run  <= 28'd1;
					bit_idx  <= '0;
				end
			end else begin
				cyc <= cyc + 28'd1;
				if (low_open) begin
					if (rx_line)
						low_open <= 1'b0;
					else
						low_run <= low_run + 28'd1;
				end
				// mid-bit of slot n sits at n + 1.5 bit periods
				if (cyc == bit_cycles * (bit_idx + 28'd1) + bit_cycles / 2) begin
					if (bit_idx < 4'd8) begin
						shreg   <= {rx_line, shreg[7:1]};
						bit_idx <= bit_idx + 4'd1;
					end else begin
						rx_byte    <= shreg;
						rx_stop    <= rx_line;
						rx_start_w <= start_width(low_run, shreg);
						rx_valid   <= 1'b1;
						active     <= 1'b0;
					end
				end
			end
		end
	end

endmodule

// ==== test/commu_tb.sv ====
// commu testbench: configurations, packet capture and checks against reference tables
module commu_tb;
	import commu_pkg::*;

	localparam int N_PKT = 5;

	logic        clk_sys;
	logic        arst_n;
	logic [7:0]  cfg_num_dev;
	logic [7:0]  cfg_sample;
	logic        pkg_start;
	logic [7:0]  data_in;
	logic        data_rd;
	logic        tx_line;
	logic        tx_busy;
	logic        pkg_done;
	logic [15:0] len_pkg;
	logic [1:0]  mode_num_dev;
	logic [15:0] tbit_frq;
	logic [19:0] tbit_period;

	logic        rx_valid;
	logic [7:0]  rx_byte;
	logic        rx_stop;
	logic [27:0] rx_start_w;
	logic [27:0] exp_cycles;

	logic [7:0]  rx_q[$];
	logic [7:0]  load_q[$];
	logic [15:0] exp_seq;
	int          err_cnt;
	int          chk_cnt;

	commu_top uut (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.cfg_num_dev  (cfg_num_dev),
		.cfg_sample   (cfg_sample),
		.pkg_start    (pkg_start),
		.data_in      (data_in),
		.data_rd      (data_rd),
		.tx_line      (tx_line),
		.tx_busy      (tx_busy),
		.pkg_done     (pkg_done),
		.len_pkg      (len_pkg),
		.mode_num_dev (mode_num_dev),
		.tbit_frq     (tbit_frq),
		.tbit_period  (tbit_period)
	);

	commu_rx_model u_rx (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.rx_line    (tx_line),
		.bit_cycles (exp_cycles),
		.rx_valid   (rx_valid),
		.rx_byte    (rx_byte),
		.rx_stop    (rx_stop),
		.rx_start_w (rx_start_w)
	);

	// ------------------------------------------------------------------------
	// run list and reference tables
	// ------------------------------------------------------------------------
	function automatic logic [7:0] cfg_dev(input int idx);
		case (idx)
			0:       return 8'd20;
			1:       return 8'd10;
			2:       return 8'd3;
			3:       return 8'd18;
			default: return 8'd12;
		endcase
	endfunction

	function automatic logic [7:0] cfg_smp(input int idx);
		case (idx)
			0:       return 8'd20;
			1:       return 8'd5;
			2:       return 8'd1;
			default: return 8'd2;
		endcase
	endfunction

	function automatic logic [15:0] ref_len(input logic [7:0] smp);
		logic [15:0] load;
		case (smp)
			8'd10:   load = LOAD_10;
			8'd5:    load = LOAD_5;
			8'd2:    load = LOAD_2;
			8'd1:    load = LOAD_1;
			default: load = LOAD_20;
		endcase
		return LEN_HEAD + load + LEN_TAIL + LEN_CRC;
	endfunction

	function automatic logic [1:0] ref_mode(input logic [7:0] dev);
		if (dev >= 8'd16)
			return MODE_HIGH;
		if (dev >= 8'd8)
			return MODE_MID;
		return MODE_LOW;
	endfunction

	// bit frequency per mode, column order 10/5/2/1/other
	function automatic logic [15:0] ref_frq(input logic [1:0] mode, input logic [7:0] smp);
		int col;
		col = (smp == 8'd10) ? 0 : (smp == 8'd5) ? 1 : (smp == 8'd2) ? 2 : (smp == 8'd1) ? 3 : 4;
		if (mode == MODE_HIGH)
			return (col == 0) ? 4000 : (col == 1) ? 2000 : (col == 2) ? 1000 : (col == 3) ? 500 : 5000;
		if (mode == MODE_MID)
			return (col == 0) ? 2000 : (col == 1) ? 1000 : (col == 2) ? 500 : (col == 3) ? 200 : 4000;
		return (col == 0) ? 1000 : (col == 1) ? 500 : (col == 2) ? 200 : (col == 3) ? 200 : 2000;
	endfunction

	function automatic logic [19:0] ref_period(input logic [15:0] frq);
		case (frq)
			16'd4000: return 20'd25;
			16'd2000: return 20'd50;
			16'd1000: return 20'd100;
			16'd500:  return 20'd200;
			16'd200:  return 20'd500;
			16'd100:  return 20'd1000;
			default:  return 20'd20;
		endcase
	endfunction

	// bit-serial CCITT step, msb of the byte first
	function automatic logic [15:0] crc_bits(input logic [15:0] crc, input logic [7:0] data);
		logic [15:0] c;
		logic        fb;
		int          i;
		c = crc;
		for (i = 7; i >= 0; i--) begin
			fb = c[15] ^ data[i];
			c = c << 1;
			if (fb)
				c = c ^ CRC_POLY;
		end
		return c;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		chk_cnt++;
		assert (got === exp) else begin
			err_cnt++;
			$display("[ERROR] %s expected %h got %h", name, exp, got);
		end
	endtask

	// ------------------------------------------------------------------------
	// clock, payload source and receive capture
	// ------------------------------------------------------------------------
	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		if (data_rd) begin
			load_q.push_back(data_in);
			data_in <= data_in + 8'd1;
		end
	end

	always @(posedge clk_sys) begin
		if (rx_valid) begin
			rx_q.push_back(rx_byte);
			check_val("start_width", exp_cycles, rx_start_w);
			check_val("stop_bit", 32'd1, rx_stop);
		end
	end

	// ------------------------------------------------------------------------
	// one packet: configure, start, optional busy start, then compare
	// ------------------------------------------------------------------------
	task automatic run_packet(input int idx, input bit busy_start);
		logic [7:0]  dev;
		logic [7:0]  smp;
		logic [15:0] exp_len;
		logic [19:0] exp_per;
		logic [15:0] crc;
		logic [7:0]  exp_b[$];
		int          bit_cyc;
		int          gap;
		int          i;
		dev = cfg_dev(idx);
		smp = cfg_smp(idx);
		exp_len = ref_len(smp);
		exp_per = ref_period(ref_frq(ref_mode(dev), smp));
		bit_cyc = exp_per * UNIT_CYCLES;
		@(posedge clk_sys);
		cfg_num_dev <= dev;
		cfg_sample  <= smp;
		exp_cycles  <= bit_cyc;
		repeat (3) @(posedge clk_sys);
		check_val("len_pkg", exp_len, len_pkg);
		check_val("mode_num_dev", ref_mode(dev), mode_num_dev);
		check_val("tbit_frq", ref_frq(ref_mode(dev), smp), tbit_frq);
		check_val("tbit_period", exp_per, tbit_period);
		rx_q.delete();
		load_q.delete();
		pkg_start <= 1'b1;
		@(posedge clk_sys);
		pkg_start <= 1'b0;
		if (busy_start) begin
			gap = $urandom_range((exp_len - 1) * 10 * bit_cyc, 10 * bit_cyc);
			repeat (gap) @(posedge clk_sys);
			assert (tx_busy) else begin
				err_cnt++;
				$display("second start landed outside the busy packet");
			end
			pkg_start <= 1'b1;
			@(posedge clk_sys);
			pkg_start <= 1'b0;
		end
		while (!pkg_done)
			@(posedge clk_sys);
		@(posedge clk_sys);
		check_val("tx_busy", 32'd0, tx_busy);

		// expected header
		exp_b.push_back(SYNC_0);
		exp_b.push_back(SYNC_1);
		exp_b.push_back(dev);
		exp_b.push_back(smp);
		exp_b.push_back(exp_len[15:8]);
		exp_b.push_back(exp_len[7:0]);
		exp_b.push_back(exp_seq[15:8]);
		exp_b.push_back(exp_seq[7:0]);
		for (i = 0; i < 4; i++)
			exp_b.push_back(8'h00);
		check_val("payload_count", exp_len - LEN_HEAD - LEN_TAIL - LEN_CRC, load_q.size());
		foreach (load_q[j])
			exp_b.push_back(load_q[j]);
		crc = CRC_INIT;
		foreach (exp_b[j])
			crc = crc_bits(crc, exp_b[j]);
		exp_b.push_back(crc[15:8]);
		exp_b.push_back(crc[7:0]);

		check_val("byte_count", exp_len, rx_q.size());
		for (i = 0; i < exp_b.size() && i < rx_q.size(); i++)
			check_val($sformatf("rx_byte[%0d]", i), exp_b[i], rx_q[i]);
		exp_seq = exp_seq + 16'd1;
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin : main_seq
		int k;
		void'($urandom(46));
		err_cnt     = 0;
		chk_cnt     = 0;
		exp_seq     = 16'd0;
		exp_cycles  = 28'd20;
		arst_n      = 1'b0;
		cfg_num_dev = 8'd0;
		cfg_sample  = 8'd0;
		pkg_start   = 1'b0;
		data_in     = 8'h00;
		repeat (4) @(posedge clk_sys);
		arst_n <= 1'b1;
		@(posedge clk_sys);
		check_val("tx_line", 32'd1, tx_line);
		check_val("tx_busy", 32'd0, tx_busy);
		check_val("data_rd", 32'd0, data_rd);
		check_val("pkg_done", 32'd0, pkg_done);

		// last packet carries the start given while busy
		for (k = 0; k < N_PKT; k++)
			run_packet(k, k == N_PKT - 1);

		$display("checks %0d errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// limit from the line time of every packet, plus margin
	initial begin : watchdog
		longint limit;
		int     k;
		limit = 0;
		for (k = 0; k < N_PKT; k++)
			limit += ref_len(cfg_smp(k)) * 10 * UNIT_CYCLES *
				ref_period(ref_frq(ref_mode(cfg_dev(k)), cfg_smp(k)));
		limit = limit + limit / 4 + 1000;
		repeat (limit) @(posedge clk_sys);
		$display("watchdog expired before the last packet was done");
		$display("test failed");
		$finish;
	end

endmodule

// ==== commu_top.f ====
rtl/commu_pkg.sv
rtl/commu_base.sv
rtl/commu_tbit.sv
rtl/commu_crc16.sv
rtl/commu_frame.sv
rtl/commu_tx.sv
rtl/commu_top.sv
test/commu_rx_model.sv
test/commu_tb.sv
